// File: verilog/BypassPkg.sv
package BypassPkg;

        // ##########################################################
        // Machine sizes
        // ##########################################################

        localparam int issueWidth = 3;                  // Issue lanes, one ALU each
        localparam int physRegs   = 64;                 // Entries in the physical register file
        localparam int physLog    = 6;                  // Bits in a physical tag
        localparam int dataWidth  = 32;                 // Operand and result width

        // ##########################################################
        // Opcodes
        // ##########################################################

        typedef enum logic [2:0]
        {
                aluAdd = 3'd0,                          // src1 + src2
                aluSub = 3'd1,                          // src1 - src2
                aluAnd = 3'd2,                          // Bitwise and
                aluOr  = 3'd3,                          // Bitwise or
                aluXor = 3'd4,                          // Bitwise xor
                aluSlt = 3'd5,                          // Signed less-than, result is 0 or 1
                aluLdi = 3'd6                           // Result is the immediate
        } opcodeT;                                      // Code 3'd7 is left unused

        // ##########################################################
        // Packets
        // ##########################################################

        // One renamed instruction as the scheduler hands it over
        typedef struct packed
        {
                logic                 valid;            // Lane carries an instruction
                opcodeT               opcode;           // ALU operation
                logic [physLog-1:0]   src1Tag;          // First physical source
                logic [physLog-1:0]   src2Tag;          // Second physical source
                logic [physLog-1:0]   destTag;          // Physical destination
                logic [dataWidth-1:0] imm;              // Immediate, only aluLdi looks at it
        } issuePkt;

        // Same instruction after both sources have been resolved to data
        typedef struct packed
        {
                logic                 valid;            // Copied from the issue packet
                opcodeT               opcode;           // ALU operation
                logic [physLog-1:0]   destTag;          // Physical destination
                logic [dataWidth-1:0] src1Data;         // Forwarded or register file value
                logic [dataWidth-1:0] src2Data;         // Forwarded or register file value
                logic [dataWidth-1:0] imm;              // Immediate
        } operandPkt;

        // Result of one lane, used for forwarding and as the write-back request
        typedef struct packed
        {
                logic                 valid;            // Result present this cycle
                logic [physLog-1:0]   tag;              // Destination register of the result
                logic [dataWidth-1:0] data;             // Result value
        } bypassPkt;

endpackage

// File: verilog/ForwardCheck.sv
`timescale 1ns/1ps

module ForwardCheck (
        input                                 clk,          // Samples the match assertion only
        input                                 rstN_i,       // Masks the assertion during reset

        input  [BypassPkg::physLog-1:0]       srcReg_i,     // Source tag to resolve
        input  [BypassPkg::dataWidth-1:0]     srcData_i,    // Register file value for that tag

        input  BypassPkg::bypassPkt           bypassPacket_i [0:BypassPkg::issueWidth-1],

        output logic [BypassPkg::dataWidth-1:0] dataOut_o   // Resolved operand
);

        import BypassPkg::*;

        logic [issueWidth-1:0] match;                   // One bit per lane whose result is ours

        // ##########################################################
        // Tag compare against every lane's result
        // ##########################################################

        always_comb
        begin
                for (int i = 0; i < issueWidth; i++)
                begin
                        // Invalid packets never match, whatever tag they hold
                        match[i] = bypassPacket_i[i].valid && (bypassPacket_i[i].tag == srcReg_i);
                end
        end

        // ##########################################################
        // Data select
        // ##########################################################

        always_comb
        begin
                dataOut_o = srcData_i;                  // No match means the register file is current
                for (int i = 0; i < issueWidth; i++)
                begin
                        if (match[i])
                        begin
                                dataOut_o = bypassPacket_i[i].data; // Bypass wins over the file
                        end
                end
        end

        // Unique destination tags among lanes in flight keep the match one-hot, so the
        // loop order above never decides which lane is forwarded
        matchOneHot: assert property (@(posedge clk) disable iff (!rstN_i)
                $onehot0(match))
                else $error("ForwardCheck: tag %0d matched several bypass packets", srcReg_i);

endmodule

// File: verilog/PhysRegFile.sv
`timescale 1ns/1ps

module PhysRegFile (
        input                                 clk,
        input                                 rstN_i,          // Synchronous, clears every entry

        // Two read ports per lane, src1 on the even index and src2 on the odd one
        input  [BypassPkg::physLog-1:0]       readTag_i  [0:2*BypassPkg::issueWidth-1],
        output logic [BypassPkg::dataWidth-1:0] readData_o [0:2*BypassPkg::issueWidth-1],

        // One write port per lane, fed straight from the bypass bus
        input  BypassPkg::bypassPkt           writePkt_i [0:BypassPkg::issueWidth-1]
);

        import BypassPkg::*;

        localparam int readPorts = 2 * issueWidth;      // Total read ports

        logic [dataWidth-1:0] regFile [0:physRegs-1];   // Storage array
        logic                 tagClash;                 // Two lanes write the same tag

        // ##########################################################
        // Read ports
        // ##########################################################

        // Asynchronous read, a value written at an edge is visible right after it
        for (genvar p = 0; p < readPorts; p++)
        begin : genRead
                assign readData_o[p] = regFile[readTag_i[p]];
        end

        // ##########################################################
        // Write ports
        // ##########################################################

        always_ff @(posedge clk)
        begin
                if (!rstN_i)
                begin
                        for (int r = 0; r < physRegs; r++)
                        begin
                                regFile[r] <= '0;       // Every register starts at zero
                        end
                end
                else
                begin
                        for (int w = 0; w < issueWidth; w++)
                        begin
                                if (writePkt_i[w].valid)
                                begin
                                        regFile[writePkt_i[w].tag] <= writePkt_i[w].data;
                                end
                        end
                end
        end

        // Pairwise tag compare over the valid write requests
        always_comb
        begin
                tagClash = 1'b0;
                for (int a = 0; a < issueWidth; a++)
                begin
                        for (int b = a + 1; b < issueWidth; b++)
                        begin
                                if (writePkt_i[a].valid && writePkt_i[b].valid &&
                                    (writePkt_i[a].tag == writePkt_i[b].tag))
                                begin
                                        tagClash = 1'b1;        // Write order would decide the value
                                end
                        end
                end
        end

        // The scheduler keeps destinations unique, so lanes never race on an entry
        noWriteClash: assert property (@(posedge clk) disable iff (!rstN_i) !tagClash)
                else $error("PhysRegFile: two lanes write the same tag in one cycle");

endmodule

// File: verilog/RegRead.sv
`timescale 1ns/1ps

module RegRead (
        input                                 clk,             // Only sampled by the forward checks
        input                                 rstN_i,          // Only used by the forward checks

        input  BypassPkg::issuePkt            issue_i    [0:BypassPkg::issueWidth-1],

        // Register file read side, src1 tag at 2*lane and src2 tag at 2*lane+1
        output logic [BypassPkg::physLog-1:0] readTag_o  [0:2*BypassPkg::issueWidth-1],
        input  [BypassPkg::dataWidth-1:0]     readData_i [0:2*BypassPkg::issueWidth-1],

        input  BypassPkg::bypassPkt           bypass_i   [0:BypassPkg::issueWidth-1],

        output BypassPkg::operandPkt          operand_o  [0:BypassPkg::issueWidth-1]
);

        import BypassPkg::*;

        logic [dataWidth-1:0] src1Data [0:issueWidth-1]; // Resolved first operand per lane
        logic [dataWidth-1:0] src2Data [0:issueWidth-1]; // Resolved second operand per lane

        for (genvar lane = 0; lane < issueWidth; lane++)
        begin : genLane

                // ##################################################
                // Register file lookup
                // ##################################################

                assign readTag_o[2*lane]   = issue_i[lane].src1Tag;     // Even port
                assign readTag_o[2*lane+1] = issue_i[lane].src2Tag;     // Odd port

                // ##################################################
                // Operand resolution
                // ##################################################

                // A producer issued last cycle is on the bypass now and has not been
                // written yet, so these checks close the one-cycle gap
                ForwardCheck fwdSrc1 (
                        .clk            (clk),
                        .rstN_i         (rstN_i),
                        .srcReg_i       (issue_i[lane].src1Tag),
                        .srcData_i      (readData_i[2*lane]),
                        .bypassPacket_i (bypass_i),
                        .dataOut_o      (src1Data[lane])
                );

                ForwardCheck fwdSrc2 (
                        .clk            (clk),
                        .rstN_i         (rstN_i),
                        .srcReg_i       (issue_i[lane].src2Tag),
                        .srcData_i      (readData_i[2*lane+1]),
                        .bypassPacket_i (bypass_i),
                        .dataOut_o      (src2Data[lane])
                );

                // Sources are dropped here, execute needs only values and the destination
                assign operand_o[lane] = '{
                        valid:    issue_i[lane].valid,
                        opcode:   issue_i[lane].opcode,
                        destTag:  issue_i[lane].destTag,
                        src1Data: src1Data[lane],
                        src2Data: src2Data[lane],
                        imm:      issue_i[lane].imm
                };
        end

endmodule

// File: verilog/ExecLane.sv
`timescale 1ns/1ps

module ExecLane (
        input                                 clk,
        input                                 rstN_i,          // Synchronous, drops the valid bit

        input  BypassPkg::operandPkt          operand_i,       // Resolved instruction from RegRead

        output BypassPkg::bypassPkt           result_o         // Bypass and write-back request
);

        import BypassPkg::*;

        operandPkt            opReg;                    // Instruction in execute this cycle
        logic [dataWidth-1:0] aluResult;                // Combinational ALU output

        // ##########################################################
        // Execute pipeline register
        // ##########################################################

        always_ff @(posedge clk)
        begin
                opReg <= operand_i;                     // New instruction every cycle, no stall
                if (!rstN_i)
                begin
                        opReg.valid <= 1'b0;            // Only the valid bit needs a known value
                end
        end

        // ##########################################################
        // ALU
        // ##########################################################

        always_comb
        begin
                case (opReg.opcode)
                        aluAdd:
                        begin
                                aluResult = opReg.src1Data + opReg.src2Data;
                        end
                        aluSub:
                        begin
                                aluResult = opReg.src1Data - opReg.src2Data;
                        end
                        aluAnd:
                        begin
                                aluResult = opReg.src1Data & opReg.src2Data;
                        end
                        aluOr:
                        begin
                                aluResult = opReg.src1Data | opReg.src2Data;
                        end
                        aluXor:
                        begin
                                aluResult = opReg.src1Data ^ opReg.src2Data;
                        end
                        aluSlt:
                        begin
                                // Both sides read as two's complement
                                aluResult = ($signed(opReg.src1Data) < $signed(opReg.src2Data)) ?
                                            dataWidth'(1) : '0;
                        end
                        aluLdi:
                        begin
                                aluResult = opReg.imm;  // Sources are ignored
                        end
                        default:
                        begin
                                aluResult = '0;         // Unused encoding
                        end
                endcase
        end

        // ##########################################################
        // Result packet
        // ##########################################################

        assign result_o.valid = opReg.valid;            // Bubble in, bubble out
        assign result_o.tag   = opReg.destTag;
        assign result_o.data  = aluResult;

        // A valid instruction reaching execute was built from a legal opcode upstream
        legalOpcode: assert property (@(posedge clk) disable iff (!rstN_i)
                opReg.valid |-> (opReg.opcode inside {aluAdd, aluSub, aluAnd, aluOr,
                                                      aluXor, aluSlt, aluLdi}))
                else $error("ExecLane: illegal opcode %0d in execute", opReg.opcode);

endmodule

// File: verilog/BackendTop.sv
`timescale 1ns/1ps

module BackendTop (
        input                                 clk,
        input                                 rstN_i,          // Synchronous, active low

        input  BypassPkg::issuePkt            issue_i  [0:BypassPkg::issueWidth-1],

        output BypassPkg::bypassPkt           result_o [0:BypassPkg::issueWidth-1]
);

        import BypassPkg::*;

        // ##########################################################
        // Interconnect
        // ##########################################################

        logic [physLog-1:0]   readTag  [0:2*issueWidth-1]; // RegRead to register file
        logic [dataWidth-1:0] readData [0:2*issueWidth-1]; // Register file to RegRead
        operandPkt            operand  [0:issueWidth-1];   // RegRead to the execute lanes
        bypassPkt             bypassBus [0:issueWidth-1];  // Results of all lanes

        // ##########################################################
        // Register read stage
        // ##########################################################

        RegRead regRead (
                .clk        (clk),
                .rstN_i     (rstN_i),
                .issue_i    (issue_i),
                .readTag_o  (readTag),
                .readData_i (readData),
                .bypass_i   (bypassBus),                // Same-cycle forwarding
                .operand_o  (operand)
        );

        // Write ports take the bus directly, so a result lands one edge after it shows
        PhysRegFile physRegFile (
                .clk        (clk),
                .rstN_i     (rstN_i),
                .readTag_i  (readTag),
                .readData_o (readData),
                .writePkt_i (bypassBus)
        );

        // ##########################################################
        // Execute lanes
        // ##########################################################

        for (genvar lane = 0; lane < issueWidth; lane++)
        begin : genExec
                ExecLane execLane (
                        .clk       (clk),
                        .rstN_i    (rstN_i),
                        .operand_i (operand[lane]),
                        .result_o  (bypassBus[lane])
                );

                // The bus is also the visible result of the slice
                assign result_o[lane] = bypassBus[lane];
        end

endmodule

// File: bench/BackendTb.sv
`timescale 1ns/1ps

module BackendTb;

        import BypassPkg::*;

        localparam int clkPeriod    = 10;
        localparam int resetCycles  = 10;
        localparam int fillCycles   = physRegs / issueWidth + 1;  // One aluLdi per register
        localparam int chainCycles  = 12;
        localparam int randomCycles = 200;
        localparam int testCycles   = 2 + 5 + (chainCycles + 2) +
                                      (fillCycles + randomCycles + 1) + 6;
        localparam int marginCycles = 100;

        logic                 clk;
        logic                 rstN;
        issuePkt              issue     [0:issueWidth-1];    // Driven into the DUT
        bypassPkt             result    [0:issueWidth-1];    // Bypass bus as seen outside
        issuePkt              nextIssue [0:issueWidth-1];    // Staged by a test for the next cycle
        logic                 expValid  [0:issueWidth-1];    // Expected result of the issued group
        logic [physLog-1:0]   expTag    [0:issueWidth-1];
        logic [dataWidth-1:0] expData   [0:issueWidth-1];
        logic [dataWidth-1:0] shadow    [0:physRegs-1];      // Reference copy of the register file
        logic [31:0]          rngState;
        int                   errorCount;
        int                   checkCount;

        BackendTop dut (
                .clk      (clk),
                .rstN_i   (rstN),
                .issue_i  (issue),
                .result_o (result)
        );

        initial
        begin
                clk = 1'b0;
                forever #(clkPeriod / 2) clk = ~clk;
        end

        // ##########################################################
        // Reference model and helpers
        // ##########################################################

        function automatic logic [31:0] nextRandom();
                rngState = rngState ^ (rngState << 13);
                rngState = rngState ^ (rngState >> 17);
                rngState = rngState ^ (rngState << 5);
                return rngState;
        endfunction

        function automatic logic [physLog-1:0] randomTag();
                return physLog'(nextRandom());
        endfunction

        // ALU behavior as the opcode list defines it
        function automatic logic [dataWidth-1:0] refResult(opcodeT op, logic [dataWidth-1:0] a,
                                                           logic [dataWidth-1:0] b,
                                                           logic [dataWidth-1:0] imm);
                case (op)
                        aluAdd:  return a + b;
                        aluSub:  return a - b;
                        aluAnd:  return a & b;
                        aluOr:   return a | b;
                        aluXor:  return a ^ b;
                        aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        aluLdi:  return imm;
                        default: return '0;
                endcase
        endfunction

        task automatic checkValue(string name, logic [31:0] got, logic [31:0] exp);
                checkCount++;
                if (got !== exp)
                begin
                        errorCount++;
                        $display("[ERROR] %0d ns %s got %h expected %h", $time, name, got, exp);
                end
        endtask

        task automatic setLane(int lane, logic v, opcodeT op, logic [physLog-1:0] s1,
                               logic [physLog-1:0] s2, logic [physLog-1:0] d,
                               logic [dataWidth-1:0] imm);
                nextIssue[lane] = '{valid: v, opcode: op, src1Tag: s1, src2Tag: s2,
                                    destTag: d, imm: imm};
        endtask

        task automatic clearLanes();
                for (int l = 0; l < issueWidth; l++)
                begin
                        nextIssue[l] = '0;                      // Bubble on every lane
                end
        endtask

        // Three distinct tags, spacing stays below the register count so none wrap onto another
        task automatic pickDests(output logic [physLog-1:0] d [0:issueWidth-1]);
                d[0] = randomTag();
                for (int l = 1; l < issueWidth; l++)
                begin
                        d[l] = d[l-1] + 1 + physLog'(nextRandom() % 20);
                end
        endtask

        // Results of the group issued last cycle are on the bus now
        task automatic checkResults();
                for (int l = 0; l < issueWidth; l++)
                begin
                        checkValue($sformatf("result_o[%0d].valid", l), 32'(result[l].valid),
                                   32'(expValid[l]));
                        if (expValid[l])
                        begin
                                checkValue($sformatf("result_o[%0d].tag", l), 32'(result[l].tag),
                                           32'(expTag[l]));
                                checkValue($sformatf("result_o[%0d].data", l), result[l].data,
                                           expData[l]);
                                shadow[expTag[l]] = expData[l];  // Write back lands at the next edge
                        end
                end
        endtask

        // One cycle: check the previous group, then drive the staged one and predict it
        task automatic stepCycle();
                @(posedge clk);
                #1;
                checkResults();
                for (int l = 0; l < issueWidth; l++)
                begin
                        issue[l]    = nextIssue[l];
                        expValid[l] = nextIssue[l].valid;
                        expTag[l]   = nextIssue[l].destTag;
                        expData[l]  = refResult(nextIssue[l].opcode, shadow[nextIssue[l].src1Tag],
                                                shadow[nextIssue[l].src2Tag], nextIssue[l].imm);
                end
        endtask

        // ##########################################################
        // Directed tests
        // ##########################################################

        task automatic resetState();
                for (int l = 0; l < issueWidth; l++)
                begin
                        setLane(l, 1'b1, aluAdd, randomTag(), randomTag(), 6'(40 + l),
                                nextRandom());
                end
                stepCycle();                                    // First check sees the idle cycle
                clearLanes();
                stepCycle();                                    // Adds of cleared registers give zero
        endtask

        task automatic regFilePath();
                for (int l = 0; l < issueWidth; l++)
                begin
                        setLane(l, 1'b1, aluLdi, '0, '0, 6'(10 + l), nextRandom());
                end
                stepCycle();
                clearLanes();
                stepCycle();                                    // Gap so the consumers miss the bypass
                setLane(0, 1'b1, aluAdd, 6'd10, 6'd11, 6'd13, '0);
                setLane(1, 1'b1, aluSub, 6'd12, 6'd10, 6'd14, '0);
                setLane(2, 1'b1, aluSub, 6'd11, 6'd12, 6'd15, '0);
                stepCycle();
                clearLanes();
                stepCycle();
                stepCycle();
        endtask

        task automatic bypassChains();
                logic [physLog-1:0] prev [0:issueWidth-1];
                logic [physLog-1:0] dest [0:issueWidth-1];
                opcodeT             op;
                for (int l = 0; l < issueWidth; l++)
                begin
                        prev[l] = 6'(20 + l);
                        setLane(l, 1'b1, aluLdi, '0, '0, prev[l], nextRandom());
                end
                stepCycle();
                for (int c = 0; c < chainCycles; c++)
                begin
                        op = (c % 3 == 0) ? aluAdd : ((c % 3 == 1) ? aluSub : aluXor);
                        for (int l = 0; l < issueWidth; l++)
                        begin
                                dest[l] = 6'(24 + 3 * (c % 4) + l);     // Never last cycle's tags
                        end
                        setLane(0, 1'b1, op, prev[0], prev[1], dest[0], '0);  // Same and cross lane
                        setLane(1, 1'b1, op, prev[2], prev[1], dest[1], '0);
                        setLane(2, 1'b1, op, prev[0], prev[2], dest[2], '0);
                        stepCycle();
                        prev = dest;
                end
                clearLanes();
                stepCycle();
        endtask

        task automatic randomMix();
                logic [physLog-1:0] dest [0:issueWidth-1];
                int                 tag;
                for (int r = 0; r < fillCycles; r++)
                begin
                        for (int l = 0; l < issueWidth; l++)
                        begin
                                tag = r * issueWidth + l;
                                setLane(l, tag < physRegs, aluLdi, '0, '0, physLog'(tag),
                                        nextRandom());
                        end
                        stepCycle();                            // About half the values are negative
                end
                for (int c = 0; c < randomCycles; c++)
                begin
                        pickDests(dest);
                        for (int l = 0; l < issueWidth; l++)
                        begin
                                setLane(l, (nextRandom() % 8) != 0, opcodeT'(nextRandom() % 7),
                                        randomTag(), randomTag(), dest[l], nextRandom());
                        end
                        stepCycle();
                end
                clearLanes();
                stepCycle();
        endtask

        task automatic bubbles();
                for (int l = 0; l < issueWidth; l++)
                begin
                        setLane(l, 1'b1, aluLdi, '0, '0, 6'(50 + l), nextRandom());
                end
                stepCycle();
                for (int c = 0; c < 2; c++)
                begin
                        for (int l = 0; l < issueWidth; l++)
                        begin
                                // Invalid lanes aim at the same tags and must not overwrite them
                                setLane(l, 1'b0, aluLdi, '0, '0, 6'(50 + l), nextRandom());
                        end
                        stepCycle();
                end
                clearLanes();
                stepCycle();
                for (int l = 0; l < issueWidth; l++)
                begin
                        setLane(l, 1'b1, aluOr, 6'(50 + l), 6'(50 + l), 6'(55 + l), '0);
                end
                stepCycle();                                    // Read back the untouched tags
                clearLanes();
                stepCycle();
        endtask

        // ##########################################################
        // Sequence and watchdog
        // ##########################################################

        initial
        begin
                rngState   = 32'd16474;
                errorCount = 0;
                checkCount = 0;
                rstN       = 1'b0;
                for (int l = 0; l < issueWidth; l++)
                begin
                        // Valid work while reset is held, the execute lanes must still drop it
                        issue[l]     = '{valid: 1'b1, opcode: aluLdi, src1Tag: '0, src2Tag: '0,
                                         destTag: 6'(40 + l), imm: nextRandom()};
                        nextIssue[l] = '0;
                        expValid[l]  = 1'b0;                    // Nothing expected straight after reset
                        expTag[l]    = '0;
                        expData[l]   = '0;
                end
                for (int r = 0; r < physRegs; r++)
                begin
                        shadow[r] = '0;
                end
                repeat (resetCycles) @(posedge clk);
                #1;
                rstN = 1'b1;
                checkResults();                                 // Every valid bit low out of reset
                for (int l = 0; l < issueWidth; l++)
                begin
                        issue[l] = '0;
                end
                resetState();
                regFilePath();
                bypassChains();
                randomMix();
                bubbles();
                $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
                if (errorCount == 0)
                        $display("Everything OK");
                else
                        $display("Something failed");
                $finish;
        end

        initial
        begin
                #((resetCycles + testCycles + marginCycles) * clkPeriod);
                $display("Timeout: the tests did not finish within %0d cycles",
                         resetCycles + testCycles + marginCycles);
                $display("Something failed");
                $finish;
        end

endmodule

// File: project.f
verilog/BypassPkg.sv
verilog/ForwardCheck.sv
verilog/PhysRegFile.sv
verilog/RegRead.sv
verilog/ExecLane.sv
verilog/BackendTop.sv
bench/BackendTb.sv
